//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

  // datapath and register file size
  localparam int data_w = 16;
  localparam int reg_cnt = 8;

  typedef logic [$clog2(reg_cnt)-1:0] reg_idx_t;
  typedef logic [data_w-1:0] data_t;

  // alu opcodes, encoded in the top three instruction bits
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_ORR,
    OP_EOR,
    OP_LSL,
    OP_LSR,
    OP_ADC
  } alu_op_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // instruction field positions, bits 2..0 are unused
  localparam int op_msb = 15;
  localparam int op_lsb = 13;
  localparam int dst_msb = 12;
  localparam int dst_lsb = 10;
  localparam int src_a_msb = 9;
  localparam int src_a_lsb = 7;
  localparam int src_b_msb = 6;
  localparam int src_b_lsb = 4;
  localparam int set_flags_bit = 3;

endpackage

`default_nettype wire

//--- rs_pkg.sv
`default_nettype none

package rs_pkg;

  // one result tag per instruction in flight
  localparam int tag_cnt = 8;

  typedef logic [$clog2(tag_cnt)-1:0] tag_t;

  // source operand, either a value or the tag it waits on
  typedef struct packed {
    logic ready;
    tag_t tag;
    isa_pkg::data_t value;
  } operand_t;

  // flags operand, same idea for nzcv
  typedef struct packed {
    logic ready;
    tag_t tag;
    isa_pkg::nzcv_t nzcv;
  } flag_operand_t;

  typedef enum logic [1:0] {
    ENT_FREE,
    ENT_WAIT,
    ENT_READY
  } entry_state_t;

  typedef struct packed {
    entry_state_t state;
    isa_pkg::alu_op_t op;
    operand_t opa;
    operand_t opb;
    flag_operand_t flags;
    logic needs_flags;
    logic set_flags;
    isa_pkg::reg_idx_t dst_reg;
    tag_t dst_tag;
  } rs_entry_t;

endpackage

`default_nettype wire

//--- issue_if.sv
`timescale 1ns/1ns
`default_nettype none

// one renamed instruction from decode into the station
interface issue_if;
  import isa_pkg::*;
  import rs_pkg::*;

  logic valid;
  alu_op_t op;
  logic needs_flags;
  logic set_flags;
  operand_t opa;
  operand_t opb;
  flag_operand_t flags;
  reg_idx_t dst_reg;
  tag_t dst_tag;
  // level, no free station slot
  logic full;

  modport decode (
    output valid, op, needs_flags, set_flags, opa, opb, flags, dst_reg, dst_tag,
    input full
  );

  modport station (
    input valid, op, needs_flags, set_flags, opa, opb, flags, dst_reg, dst_tag,
    output full
  );

endinterface

`default_nettype wire

//--- cdb_if.sv
`timescale 1ns/1ns
`default_nettype none

// common data bus, one completion per cycle
interface cdb_if;
  import isa_pkg::*;
  import rs_pkg::*;

  logic valid;
  tag_t tag;
  reg_idx_t dst_reg;
  data_t value;
  logic set_flags;
  nzcv_t nzcv;

  modport result (output valid, tag, dst_reg, value, set_flags, nzcv);

  // decode and station both snoop the bus
  modport listener (input valid, tag, dst_reg, value, set_flags, nzcv);

endinterface

`default_nettype wire

//--- fu_if.sv
`timescale 1ns/1ns
`default_nettype none

// station to alu, no ready since the pipe takes one item every cycle
interface fu_if;
  import isa_pkg::*;
  import rs_pkg::*;

  logic start;
  alu_op_t op;
  data_t a;
  data_t b;
  logic carry_in;
  reg_idx_t dst_reg;
  tag_t dst_tag;
  logic set_flags;

  modport station (output start, op, a, b, carry_in, dst_reg, dst_tag, set_flags);

  modport alu (input start, op, a, b, carry_in, dst_reg, dst_tag, set_flags);

endinterface

`default_nettype wire

//--- instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  logic in_clk,
  input  logic in_rst,
  input  logic in_instr_valid,
  input  logic [isa_pkg::data_w-1:0] in_instr,
  output logic out_stall,
  issue_if.decode issue,
  cdb_if.listener cdb
);
  import isa_pkg::*;
  import rs_pkg::*;

  // rename entry, pending means the newest value is still in flight
  typedef struct packed {
    logic pending;
    tag_t tag;
  } rename_t;

  data_t regs [reg_cnt];
  nzcv_t flag_reg;
  rename_t reg_map [reg_cnt];
  rename_t flag_map;
  logic [tag_cnt-1:0] tag_busy;

  alu_op_t op;
  reg_idx_t dst;
  reg_idx_t src_a;
  reg_idx_t src_b;
  logic set_flags;
  logic tag_found;
  tag_t new_tag;
  logic take;

  // register value, or the pending tag, with same-cycle cdb forwarding
  function automatic operand_t lookup(rename_t map, data_t rf_value, logic bus_valid,
                                      tag_t bus_tag, data_t bus_value);
    operand_t opnd;
    opnd.ready = 1'b1;
    opnd.tag = map.tag;
    opnd.value = rf_value;
    if (map.pending) begin
      if (bus_valid && bus_tag == map.tag) begin
        opnd.value = bus_value;
      end else begin
        opnd.ready = 1'b0;
      end
    end
    return opnd;
  endfunction

  assign op = alu_op_t'(in_instr[op_msb:op_lsb]);
  assign dst = in_instr[dst_msb:dst_lsb];
  assign src_a = in_instr[src_a_msb:src_a_lsb];
  assign src_b = in_instr[src_b_msb:src_b_lsb];
  assign set_flags = in_instr[set_flags_bit];

  // lowest free tag
  always_comb begin
    tag_found = 1'b0;
    new_tag = '0;
    for (int t = tag_cnt - 1; t >= 0; t--) begin
      if (!tag_busy[t]) begin
        tag_found = 1'b1;
        new_tag = tag_t'(t);
      end
    end
  end

  assign out_stall = issue.full | ~tag_found;
  assign take = in_instr_valid & ~issue.full & tag_found;

  assign issue.valid = take;
  assign issue.op = op;
  // only add-with-carry reads the flags
  assign issue.needs_flags = (op == OP_ADC);
  assign issue.set_flags = set_flags;
  assign issue.dst_reg = dst;
  assign issue.dst_tag = new_tag;

  always_comb begin
    issue.opa = lookup(reg_map[src_a], regs[src_a], cdb.valid, cdb.tag, cdb.value);
    issue.opb = lookup(reg_map[src_b], regs[src_b], cdb.valid, cdb.tag, cdb.value);
    issue.flags.ready = 1'b1;
    issue.flags.tag = flag_map.tag;
    issue.flags.nzcv = flag_reg;
    if (issue.needs_flags && flag_map.pending) begin
      if (cdb.valid && cdb.set_flags && cdb.tag == flag_map.tag) begin
        issue.flags.nzcv = cdb.nzcv;
      end else begin
        issue.flags.ready = 1'b0;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int r = 0; r < reg_cnt; r++) begin
        regs[r] <= '0;
        reg_map[r] <= '0;
      end
      flag_reg <= '0;
      flag_map <= '0;
      tag_busy <= '0;
    end else begin
      // completion frees its tag, commits only if still the newest writer
      if (cdb.valid) begin
        tag_busy[cdb.tag] <= 1'b0;
        if (reg_map[cdb.dst_reg].pending && reg_map[cdb.dst_reg].tag == cdb.tag) begin
          regs[cdb.dst_reg] <= cdb.value;
          reg_map[cdb.dst_reg].pending <= 1'b0;
        end
        if (cdb.set_flags && flag_map.pending && flag_map.tag == cdb.tag) begin
          flag_reg <= cdb.nzcv;
          flag_map.pending <= 1'b0;
        end
      end
      // a new rename overrides a same-cycle clear
      if (take) begin
        tag_busy[new_tag] <= 1'b1;
        reg_map[dst] <= '{pending: 1'b1, tag: new_tag};
        if (set_flags) begin
          flag_map <= '{pending: 1'b1, tag: new_tag};
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
  parameter int rs_size = 4
) (
  input  logic in_clk,
  input  logic in_rst,
  issue_if.station issue,
  cdb_if.listener cdb,
  fu_if.station fu
);
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int idx_w = $clog2(rs_size);

  rs_entry_t entries [rs_size];
  rs_entry_t woken [rs_size];
  rs_entry_t new_entry;
  logic free_found;
  logic [idx_w-1:0] free_idx;
  logic sel_found;
  logic [idx_w-1:0] sel_idx;

  function automatic logic operands_ready(rs_entry_t e);
    return e.opa.ready && e.opb.ready && (e.flags.ready || !e.needs_flags);
  endfunction

  // capture a broadcast value for a waiting operand
  function automatic operand_t wake(operand_t opnd, logic bus_valid, tag_t bus_tag,
                                    data_t bus_value);
    operand_t res;
    res = opnd;
    if (bus_valid && !opnd.ready && opnd.tag == bus_tag) begin
      res.ready = 1'b1;
      res.value = bus_value;
    end
    return res;
  endfunction

  // next state of each entry after this cycle's broadcast
  always_comb begin
    for (int i = 0; i < rs_size; i++) begin
      woken[i] = entries[i];
      woken[i].opa = wake(entries[i].opa, cdb.valid, cdb.tag, cdb.value);
      woken[i].opb = wake(entries[i].opb, cdb.valid, cdb.tag, cdb.value);
      if (cdb.valid && cdb.set_flags && !entries[i].flags.ready &&
          entries[i].flags.tag == cdb.tag) begin
        woken[i].flags.ready = 1'b1;
        woken[i].flags.nzcv = cdb.nzcv;
      end
      if (entries[i].state == ENT_WAIT && operands_ready(woken[i])) begin
        woken[i].state = ENT_READY;
      end
    end
  end

  // lowest free slot and lowest ready entry
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    sel_found = 1'b0;
    sel_idx = '0;
    for (int i = rs_size - 1; i >= 0; i--) begin
      if (entries[i].state == ENT_FREE) begin
        free_found = 1'b1;
        free_idx = idx_w'(i);
      end
      if (entries[i].state == ENT_READY) begin
        sel_found = 1'b1;
        sel_idx = idx_w'(i);
      end
    end
  end

  assign issue.full = ~free_found;

  always_comb begin
    new_entry.state = ENT_WAIT;
    new_entry.op = issue.op;
    new_entry.opa = issue.opa;
    new_entry.opb = issue.opb;
    new_entry.flags = issue.flags;
    new_entry.needs_flags = issue.needs_flags;
    new_entry.set_flags = issue.set_flags;
    new_entry.dst_reg = issue.dst_reg;
    new_entry.dst_tag = issue.dst_tag;
    // decode already forwarded, so this may be ready straight away
    if (operands_ready(new_entry)) begin
      new_entry.state = ENT_READY;
    end
  end

  // issue is combinational on the selected entry
  assign fu.start = sel_found;
  assign fu.op = entries[sel_idx].op;
  assign fu.a = entries[sel_idx].opa.value;
  assign fu.b = entries[sel_idx].opb.value;
  assign fu.carry_in = entries[sel_idx].needs_flags & entries[sel_idx].flags.nzcv.c;
  assign fu.dst_reg = entries[sel_idx].dst_reg;
  assign fu.dst_tag = entries[sel_idx].dst_tag;
  assign fu.set_flags = entries[sel_idx].set_flags;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < rs_size; i++) begin
        entries[i].state <= ENT_FREE;
      end
    end else begin
      for (int i = 0; i < rs_size; i++) begin
        if (entries[i].state == ENT_WAIT) begin
          entries[i] <= woken[i];
        end
      end
      // selected entry leaves at the end of its issue cycle
      if (sel_found) begin
        entries[sel_idx].state <= ENT_FREE;
      end
      if (issue.valid) begin
        entries[free_idx] <= new_entry;
      end
    end
  end

endmodule

`default_nettype wire

//--- alu_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module alu_pipe (
  input  logic in_clk,
  input  logic in_rst,
  fu_if.alu fu,
  output logic res_valid,
  output isa_pkg::data_t res_value,
  output logic res_carry,
  output logic res_ovf,
  output isa_pkg::reg_idx_t res_reg,
  output rs_pkg::tag_t res_tag,
  output logic res_set_flags,
  output isa_pkg::alu_op_t res_op
);
  import isa_pkg::*;
  import rs_pkg::*;

  // stage 1 operand registers
  logic s1_valid;
  alu_op_t s1_op;
  data_t s1_a;
  data_t s1_b;
  logic s1_cin;
  reg_idx_t s1_reg;
  tag_t s1_tag;
  logic s1_set_flags;

  data_t value;
  logic carry;
  logic ovf;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= fu.start;
    end
    s1_op <= fu.op;
    s1_a <= fu.a;
    s1_b <= fu.b;
    s1_cin <= fu.carry_in;
    s1_reg <= fu.dst_reg;
    s1_tag <= fu.dst_tag;
    s1_set_flags <= fu.set_flags;
  end

  // stage 2 compute
  always_comb begin
    logic [data_w:0] sum;
    data_t b_eff;
    logic cin_eff;
    // sub is a plus not b plus one, carry out means no borrow
    b_eff = (s1_op == OP_SUB) ? ~s1_b : s1_b;
    cin_eff = (s1_op == OP_SUB) ? 1'b1 : (s1_op == OP_ADC) & s1_cin;
    sum = {1'b0, s1_a} + {1'b0, b_eff} + {{data_w{1'b0}}, cin_eff};
    value = '0;
    carry = 1'b0;
    ovf = 1'b0;
    case (s1_op)
      OP_ADD, OP_SUB, OP_ADC: begin
        value = sum[data_w-1:0];
        carry = sum[data_w];
        // signed overflow, operands agree in sign but result does not
        ovf = (s1_a[data_w-1] == b_eff[data_w-1]) && (value[data_w-1] != s1_a[data_w-1]);
      end
      OP_AND: value = s1_a & s1_b;
      OP_ORR: value = s1_a | s1_b;
      OP_EOR: value = s1_a ^ s1_b;
      OP_LSL: value = s1_a << s1_b[3:0];
      OP_LSR: value = s1_a >> s1_b[3:0];
      default: value = '0;
    endcase
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid;
    end
    res_value <= value;
    res_carry <= carry;
    res_ovf <= ovf;
    res_reg <= s1_reg;
    res_tag <= s1_tag;
    res_set_flags <= s1_set_flags;
    res_op <= s1_op;
  end

endmodule

`default_nettype wire

//--- result_bus.sv
`timescale 1ns/1ns
`default_nettype none

module result_bus (
  input  logic in_clk,
  input  logic in_rst,
  input  logic res_valid,
  input  isa_pkg::data_t res_value,
  input  logic res_carry,
  input  logic res_ovf,
  input  isa_pkg::reg_idx_t res_reg,
  input  rs_pkg::tag_t res_tag,
  input  logic res_set_flags,
  input  isa_pkg::alu_op_t res_op,
  cdb_if.result cdb,
  output logic out_wb_valid,
  output isa_pkg::reg_idx_t out_wb_reg,
  output isa_pkg::data_t out_wb_value,
  output logic out_wb_flags_valid,
  output isa_pkg::nzcv_t out_wb_flags
);
  import isa_pkg::*;
  import rs_pkg::*;

  nzcv_t flags;
  logic arith;
  logic wb_valid;
  tag_t wb_tag;
  reg_idx_t wb_reg;
  data_t wb_value;
  logic wb_set_flags;
  nzcv_t wb_flags;

  // c and v only mean something for add, sub and adc
  assign arith = (res_op == OP_ADD) || (res_op == OP_SUB) || (res_op == OP_ADC);
  assign flags = '{n: res_value[data_w-1], z: (res_value == '0),
                   c: arith & res_carry, v: arith & res_ovf};

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= res_valid;
    end
    wb_tag <= res_tag;
    wb_reg <= res_reg;
    wb_value <= res_value;
    wb_set_flags <= res_set_flags;
    wb_flags <= flags;
  end

  // cdb and writeback ports share the one register
  assign cdb.valid = wb_valid;
  assign cdb.tag = wb_tag;
  assign cdb.dst_reg = wb_reg;
  assign cdb.value = wb_value;
  assign cdb.set_flags = wb_set_flags;
  assign cdb.nzcv = wb_flags;

  assign out_wb_valid = wb_valid;
  assign out_wb_reg = wb_reg;
  assign out_wb_value = wb_value;
  assign out_wb_flags_valid = wb_valid & wb_set_flags;
  assign out_wb_flags = wb_flags;

endmodule

`default_nettype wire

//--- rs_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rs_core_top #(
  parameter int rs_size = 4
) (
  input  logic in_clk,
  input  logic in_rst,
  input  logic in_instr_valid,
  input  logic [isa_pkg::data_w-1:0] in_instr,
  output logic out_stall,
  output logic out_wb_valid,
  output isa_pkg::reg_idx_t out_wb_reg,
  output isa_pkg::data_t out_wb_value,
  output logic out_wb_flags_valid,
  output isa_pkg::nzcv_t out_wb_flags
);
  import isa_pkg::*;
  import rs_pkg::*;

  issue_if issue_bus ();
  cdb_if cdb_bus ();
  fu_if fu_bus ();

  // alu result into the result stage
  logic res_valid;
  data_t res_value;
  logic res_carry;
  logic res_ovf;
  reg_idx_t res_reg;
  tag_t res_tag;
  logic res_set_flags;
  alu_op_t res_op;

  instr_decode instr_decode_inst (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .in_instr_valid(in_instr_valid),
    .in_instr(in_instr),
    .out_stall(out_stall),
    .issue(issue_bus.decode),
    .cdb(cdb_bus.listener)
  );

  reservation_station #(
    .rs_size(rs_size)
  ) reservation_station_inst (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .issue(issue_bus.station),
    .cdb(cdb_bus.listener),
    .fu(fu_bus.station)
  );

  alu_pipe alu_pipe_inst (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .fu(fu_bus.alu),
    .res_valid(res_valid),
    .res_value(res_value),
    .res_carry(res_carry),
    .res_ovf(res_ovf),
    .res_reg(res_reg),
    .res_tag(res_tag),
    .res_set_flags(res_set_flags),
    .res_op(res_op)
  );

  result_bus result_bus_inst (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .res_valid(res_valid),
    .res_value(res_value),
    .res_carry(res_carry),
    .res_ovf(res_ovf),
    .res_reg(res_reg),
    .res_tag(res_tag),
    .res_set_flags(res_set_flags),
    .res_op(res_op),
    .cdb(cdb_bus.result),
    .out_wb_valid(out_wb_valid),
    .out_wb_reg(out_wb_reg),
    .out_wb_value(out_wb_value),
    .out_wb_flags_valid(out_wb_flags_valid),
    .out_wb_flags(out_wb_flags)
  );

endmodule

`default_nettype wire

//--- tb_rs_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rs_core;
  import isa_pkg::*;

  localparam int timeout_cycles = 300;

  // expected writeback for one register
  typedef struct {
    reg_idx_t dst;
    data_t value;
    logic fv;
    nzcv_t flags;
  } exp_t;

  // directed program with hand-computed results
  typedef struct {
    logic [15:0] instr;
    data_t value;
    logic fv;
    nzcv_t flags;
  } vec_t;

  logic in_clk;
  logic in_rst;
  logic in_instr_valid;
  logic [15:0] in_instr;
  logic out_stall;
  logic out_wb_valid;
  reg_idx_t out_wb_reg;
  data_t out_wb_value;
  logic out_wb_flags_valid;
  nzcv_t out_wb_flags;

  exp_t pend[$];
  vec_t table_vec[21];
  data_t model_regs[reg_cnt];
  nzcv_t model_flags;
  int err_cnt = 0;
  int issued_count = 0;
  int wb_count = 0;
  logic saw_stall = 1'b0;
  integer seed = 47780;

  // checker scratch
  int first_idx;
  int match_idx;

  rs_core_top #(.rs_size(4)) rs_core_top_inst (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .in_instr_valid(in_instr_valid),
    .in_instr(in_instr),
    .out_stall(out_stall),
    .out_wb_valid(out_wb_valid),
    .out_wb_reg(out_wb_reg),
    .out_wb_value(out_wb_value),
    .out_wb_flags_valid(out_wb_flags_valid),
    .out_wb_flags(out_wb_flags)
  );

  initial in_clk = 1'b0;
  always #20 in_clk = ~in_clk;

  task automatic fail_stop(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [15:0] encode(alu_op_t op, int dst, int a, int b, logic sf);
    return {op, 3'(dst), 3'(a), 3'(b), sf, 3'b000};
  endfunction

  // sequential reference that updates the model registers and flags
  task automatic model_exec(input logic [15:0] w, output exp_t e);
    logic [2:0] op;
    data_t a;
    data_t b;
    logic [16:0] wide;
    data_t res;
    nzcv_t f;
    op = w[15:13];
    a = model_regs[w[9:7]];
    b = model_regs[w[6:4]];
    f = '0;
    wide = '0;
    case (op)
      3'd0: wide = {1'b0, a} + {1'b0, b};
      3'd1: wide = {1'b0, a} - {1'b0, b};
      3'd7: wide = {1'b0, a} + {1'b0, b} + 17'(model_flags.c);
      3'd2: wide = {1'b0, a & b};
      3'd3: wide = {1'b0, a | b};
      3'd4: wide = {1'b0, a ^ b};
      3'd5: wide = {1'b0, a << b[3:0]};
      default: wide = {1'b0, a >> b[3:0]};
    endcase
    res = wide[15:0];
    f.n = res[15];
    f.z = (res == 16'h0000);
    if (op == 3'd0 || op == 3'd7) begin
      f.c = wide[16];
      f.v = (a[15] == b[15]) && (res[15] != a[15]);
    end else if (op == 3'd1) begin
      // no borrow sets carry
      f.c = (a >= b);
      f.v = (a[15] != b[15]) && (res[15] != a[15]);
    end
    model_regs[w[12:10]] = res;
    if (w[3]) begin
      model_flags = f;
    end
    e = '{dst: w[12:10], value: res, fv: w[3], flags: f};
  endtask

  // hold the word until the DUT takes it
  task automatic apply_instr(input logic [15:0] w);
    int waited;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    in_instr = w;
    in_instr_valid = 1'b1;
    while (!accepted) begin
      accepted = !out_stall;
      if (out_stall) begin
        saw_stall = 1'b1;
      end
      @(posedge in_clk);
      #2;
      waited++;
      assert (waited < timeout_cycles)
        else fail_stop("instruction was held off by out_stall past the timeout");
    end
    issued_count++;
  endtask

  task automatic issue_model(input logic [15:0] w);
    exp_t e;
    model_exec(w, e);
    pend.push_back(e);
    apply_instr(w);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    in_instr_valid = 1'b0;
    while (wb_count != issued_count) begin
      @(posedge in_clk);
      #2;
      waited++;
      assert (waited < timeout_cycles)
        else fail_stop($sformatf("writebacks stalled at %0d of %0d", wb_count, issued_count));
    end
  endtask

  function automatic string mismatch_text(int idx);
    if (pend[idx].value != out_wb_value) begin
      return $sformatf("FAILED time=%0t out_wb_value r%0d expected=%h got=%h",
                       $time, out_wb_reg, pend[idx].value, out_wb_value);
    end
    if (pend[idx].fv != out_wb_flags_valid) begin
      return $sformatf("FAILED time=%0t out_wb_flags_valid expected=%b got=%b",
                       $time, pend[idx].fv, out_wb_flags_valid);
    end
    return $sformatf("FAILED time=%0t out_wb_flags expected=%b got=%b",
                     $time, pend[idx].flags, out_wb_flags);
  endfunction

  // outputs settle after the rising edge so sample them mid-cycle
  always @(negedge in_clk) begin
    if (!in_rst && out_wb_valid) begin
      wb_count++;
      first_idx = -1;
      match_idx = -1;
      foreach (pend[i]) begin
        if (pend[i].dst == out_wb_reg) begin
          if (first_idx < 0) begin
            first_idx = i;
          end
          if (match_idx < 0 && pend[i].value == out_wb_value &&
              pend[i].fv == out_wb_flags_valid &&
              (!pend[i].fv || pend[i].flags == out_wb_flags)) begin
            match_idx = i;
          end
        end
      end
      assert (first_idx >= 0)
        else fail_stop($sformatf("writeback to r%0d at %0t had no pending instruction",
                                 out_wb_reg, $time));
      assert (match_idx >= 0) else fail_stop(mismatch_text(first_idx));
      pend.delete(match_idx);
    end
  end

  initial begin
    int lat;
    in_rst = 1'b1;
    in_instr_valid = 1'b0;
    in_instr = '0;
    model_flags = '0;
    for (int r = 0; r < reg_cnt; r++) begin
      model_regs[r] = '0;
    end

    // flags are n z c v
    table_vec[0]  = '{encode(OP_SUB, 0, 0, 0, 1), 16'h0000, 1'b1, 4'b0110};
    table_vec[1]  = '{encode(OP_ADC, 1, 0, 0, 0), 16'h0001, 1'b0, 4'b0000};
    table_vec[2]  = '{encode(OP_LSL, 2, 1, 1, 0), 16'h0002, 1'b0, 4'b0000};
    table_vec[3]  = '{encode(OP_ADD, 3, 2, 1, 1), 16'h0003, 1'b1, 4'b0000};
    table_vec[4]  = '{encode(OP_LSL, 4, 3, 3, 1), 16'h0018, 1'b1, 4'b0000};
    table_vec[5]  = '{encode(OP_ORR, 5, 4, 3, 1), 16'h001b, 1'b1, 4'b0000};
    table_vec[6]  = '{encode(OP_AND, 6, 5, 3, 1), 16'h0003, 1'b1, 4'b0000};
    table_vec[7]  = '{encode(OP_EOR, 6, 6, 3, 1), 16'h0000, 1'b1, 4'b0100};
    table_vec[8]  = '{encode(OP_LSR, 6, 4, 2, 1), 16'h0006, 1'b1, 4'b0000};
    table_vec[9]  = '{encode(OP_LSL, 7, 4, 4, 0), 16'h1800, 1'b0, 4'b0000};
    table_vec[10] = '{encode(OP_LSL, 7, 7, 3, 1), 16'hc000, 1'b1, 4'b1000};
    // carry out with negative result
    table_vec[11] = '{encode(OP_ADD, 0, 7, 7, 1), 16'h8000, 1'b1, 4'b1010};
    table_vec[12] = '{encode(OP_LSR, 5, 7, 1, 0), 16'h6000, 1'b0, 4'b0000};
    // positive overflow
    table_vec[13] = '{encode(OP_ADD, 5, 5, 5, 1), 16'hc000, 1'b1, 4'b1001};
    table_vec[14] = '{encode(OP_ADD, 4, 0, 0, 1), 16'h0000, 1'b1, 4'b0111};
    // borrow clears carry
    table_vec[15] = '{encode(OP_SUB, 2, 1, 3, 1), 16'hfffe, 1'b1, 4'b1000};
    table_vec[16] = '{encode(OP_SUB, 3, 5, 6, 1), 16'hbffa, 1'b1, 4'b1010};
    // independent op between the sub and the adc
    table_vec[17] = '{encode(OP_ORR, 7, 1, 1, 0), 16'h0001, 1'b0, 4'b0000};
    table_vec[18] = '{encode(OP_ADC, 1, 1, 1, 1), 16'h0003, 1'b1, 4'b0000};
    table_vec[19] = '{encode(OP_ADC, 6, 1, 6, 1), 16'h0009, 1'b1, 4'b0000};
    table_vec[20] = '{encode(OP_LSR, 0, 0, 0, 1), 16'h8000, 1'b1, 4'b1000};

    repeat (3) @(posedge in_clk);
    #2;
    in_rst = 1'b0;
    assert (!out_stall && !out_wb_valid)
      else fail_stop("out_stall or out_wb_valid is high after reset");

    // single add into an empty station has a fixed latency
    pend.push_back('{dst: 3'd0, value: 16'h0000, fv: 1'b1, flags: 4'b0100});
    apply_instr(encode(OP_ADD, 0, 0, 0, 1));
    in_instr_valid = 1'b0;
    lat = 1;
    while (!out_wb_valid) begin
      @(posedge in_clk);
      #2;
      lat++;
      assert (lat < timeout_cycles) else fail_stop("no writeback for the first add");
    end
    assert (lat == 4)
      else fail_stop($sformatf("FAILED time=%0t out_wb_valid latency expected=4 got=%0d",
                               $time, lat));
    assert (out_wb_reg == 3'd0)
      else fail_stop($sformatf("FAILED time=%0t out_wb_reg expected=0 got=%0d",
                               $time, out_wb_reg));
    wait_drain();

    // directed table back to back
    foreach (table_vec[i]) begin
      pend.push_back('{dst: table_vec[i].instr[12:10], value: table_vec[i].value,
                       fv: table_vec[i].fv, flags: table_vec[i].flags});
      model_regs[table_vec[i].instr[12:10]] = table_vec[i].value;
      if (table_vec[i].fv) begin
        model_flags = table_vec[i].flags;
      end
      apply_instr(table_vec[i].instr);
    end
    wait_drain();

    // long chain on r1 and then a burst waiting on it
    saw_stall = 1'b0;
    for (int i = 0; i < 6; i++) begin
      issue_model(encode(OP_ADD, 1, 1, 1, 1));
    end
    for (int i = 0; i < 10; i++) begin
      issue_model(encode(i[0] ? OP_EOR : OP_ADD, 2 + (i % 6), 1, 1 + (i % 3), 0));
    end
    wait_drain();
    assert (saw_stall) else fail_stop("out_stall never rose while the station was full");

    // random program against the reference model
    for (int i = 0; i < 200; i++) begin
      issue_model(16'($random(seed)));
    end
    wait_drain();
    assert (pend.size() == 0)
      else fail_stop($sformatf("%0d expectations still pending at the end", pend.size()));

    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rs_core.f
isa_pkg.sv
rs_pkg.sv
issue_if.sv
cdb_if.sv
fu_if.sv
instr_decode.sv
reservation_station.sv
alu_pipe.sv
result_bus.sv
rs_core_top.sv
tb_rs_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rs_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f rs_core.f --top-module tb_rs_core -o sim_tb_rs_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_rs_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
